//--- common/divCtrlPkg.sv
/* sequencer control types
   state encoding and iteration index */

`include "fpDiv_defs.svh"

package divCtrlPkg;

  typedef enum logic [1:0]
  {
    Idle,
    Load,     // first cell step on fresh operands
    Iterate   // remaining cell steps
  } seqState_t;

  // index 0 to ITER_CYCLES-1
  typedef logic [$clog2(`ITER_CYCLES)-1:0] stepCnt_t;

endpackage

//--- common/divOperandIf.sv
/* operand bundle of one division
   mantissas with hidden bit and biased exponents */

interface divOperandIf;

  import fpFormatPkg::*;

  mant_t Numerator;
  mant_t Denominator;
  exp_t  ExpNum;
  exp_t  ExpDen;

  ////////////////////////////////////////////////////////////
  // consumers
  ////////////////////////////////////////////////////////////

  // mantissa datapath
  modport mant
  (
    input Numerator,
    input Denominator
  );

  // exponent datapath
  modport exp
  (
    input ExpNum,
    input ExpDen
  );

endinterface

//--- common/fpDiv_defs.svh
/* fp divider dimensions
   operand widths, exponent bias and iteration schedule */

`ifndef FPDIV_DEFS_SVH
`define FPDIV_DEFS_SVH

// mantissa incl. hidden bit
`define MANT_WIDTH 24

// biased exponent field
`define EXP_WIDTH 8
`define EXP_BIAS 127

////////////////////////////////////////////////////////////
// iteration schedule
////////////////////////////////////////////////////////////

// quotient bits retired per clock
`define CELLS_PER_CYCLE 4

// 6 x 4 = 24 quotient bits
`define ITER_CYCLES 6

`endif

//--- common/fpFormatPkg.sv
/* number format types of the divider
   mantissa, partial remainder and exponent vectors */

`include "fpDiv_defs.svh"

package fpFormatPkg;

  // operand or quotient mantissa, hidden bit at the top
  typedef logic [`MANT_WIDTH-1:0] mant_t;

  // partial remainder, one bit wider for the sign
  typedef logic signed [`MANT_WIDTH:0] rem_t;

  // biased input exponent
  typedef logic [`EXP_WIDTH-1:0] exp_t;

  // prenormalized result exponent
  // wraps modulo 512, no saturation here
  typedef logic [`EXP_WIDTH:0] expRes_t;

endpackage

//--- hdl/divSequencer.sv
/* divider sequencer
   drives load and iteration strobes, holds Ready and pulses Done */

`include "fpDiv_defs.svh"

module divSequencer
(
  input  logic Clk_CI,
  input  logic Rst_RBI,
  input  logic Start,
  output logic Load,
  output logic Iterate,
  output logic Last,
  output logic Ready,
  output logic Done
);

  import divCtrlPkg::*;

  seqState_t stateCur;
  seqState_t stateNext;
  stepCnt_t  stepCur;
  stepCnt_t  stepNext;
  logic      finalStep;

  assign finalStep = (stepCur == stepCnt_t'(`ITER_CYCLES - 1));

  always_comb
  begin
    stateNext = stateCur;
    stepNext  = '0;   // idle keeps index at 0
    unique case (stateCur)
      divCtrlPkg::Idle:
      begin
        if (Start)
          stateNext = divCtrlPkg::Load;
      end
      divCtrlPkg::Load:
      begin
        stateNext = divCtrlPkg::Iterate;
        stepNext  = stepCnt_t'(stepCur + 1);
      end
      divCtrlPkg::Iterate:
      begin
        if (finalStep)
          stateNext = divCtrlPkg::Idle;
        else
          stepNext = stepCnt_t'(stepCur + 1);
      end
      default:
        stateNext = divCtrlPkg::Idle;
    endcase
  end

  assign Load    = (stateCur == divCtrlPkg::Load);
  assign Iterate = (stateCur != divCtrlPkg::Idle);  // load counts as first step
  assign Last    = (stateCur == divCtrlPkg::Iterate) && finalStep;

  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      stateCur <= divCtrlPkg::Idle;
      stepCur  <= '0;
      Ready    <= 1'b1;
      Done     <= 1'b0;
    end
    else
    begin
      stateCur <= stateNext;
      stepCur  <= stepNext;
      Done     <= Last;
      if (Start)
        Ready <= 1'b0;
      else if (Last)
        Ready <= 1'b1;   // back up together with Done
    end
  end

  // no restart while an operation is in flight
  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI) Start |-> Ready)
    else $error("divSequencer: Start while busy");

  // fixed schedule from load to the Done pulse
  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
                   Load |-> ##5 Last ##1 (Done && Ready))
    else $error("divSequencer: Last or Done/Ready off schedule");

endmodule

//--- hdl/expDivider.sv
/* exponent path of the divider
   biased difference ExpNum - ExpDen + bias, taken on load */

`include "fpDiv_defs.svh"

module expDivider
(
  input  logic                 Clk_CI,
  input  logic                 Rst_RBI,
  input  logic                 Load,
  divOperandIf.exp             Ops,
  output fpFormatPkg::expRes_t ExpDiff
);

  import fpFormatPkg::*;

  expRes_t expSum;

  ////////////////////////////////////////////////////////////
  // biased difference
  ////////////////////////////////////////////////////////////

  // 9 bit one's complement of ExpDen, its +1 merged into the bias
  assign expSum = expRes_t'({1'b0, Ops.ExpNum})
                + ~expRes_t'({1'b0, Ops.ExpDen})
                + expRes_t'(`EXP_BIAS + 1);

  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      ExpDiff <= '0;
    end
    else if (Load)
    begin
      ExpDiff <= expSum;   // wraps mod 512
    end
  end

endmodule

//--- hdl/fpDivCore.sv
/* single precision divider core
   mantissa and exponent datapaths side by side, fixed 7 cycle latency */

module fpDivCore
(
  input  logic                 Clk_CI,
  input  logic                 Rst_RBI,
  input  logic                 Start,
  input  fpFormatPkg::mant_t   Numerator,
  input  fpFormatPkg::mant_t   Denominator,
  input  fpFormatPkg::exp_t    ExpNum,
  input  fpFormatPkg::exp_t    ExpDen,
  output logic                 Ready,
  output logic                 Done,
  output fpFormatPkg::mant_t   MantResult,
  output fpFormatPkg::expRes_t ExpResult
);

  import fpFormatPkg::*;

  logic    load;
  logic    iterate;
  logic    last;
  mant_t   quotient;
  logic    roundBit;
  expRes_t expDiff;

  // operands, valid with Start and in the load cycle
  divOperandIf ops ();

  assign ops.Numerator   = Numerator;
  assign ops.Denominator = Denominator;
  assign ops.ExpNum      = ExpNum;
  assign ops.ExpDen      = ExpDen;

  divSequencer sequencer
  (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .Start   (Start),
    .Load    (load),
    .Iterate (iterate),
    .Last    (last),
    .Ready   (Ready),
    .Done    (Done)
  );

  mantDivider mantDiv
  (
    .Clk_CI   (Clk_CI),
    .Rst_RBI  (Rst_RBI),
    .Load     (load),
    .Iterate  (iterate),
    .Ops      (ops.mant),
    .Quotient (quotient),
    .RoundBit (roundBit)
  );

  expDivider expDiv
  (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .Load    (load),
    .Ops     (ops.exp),
    .ExpDiff (expDiff)
  );

  resultAssembler assembler
  (
    .Clk_CI     (Clk_CI),
    .Rst_RBI    (Rst_RBI),
    .Last       (last),
    .Quotient   (quotient),
    .RoundBit   (roundBit),
    .ExpDiff    (expDiff),
    .MantResult (MantResult),
    .ExpResult  (ExpResult)
  );

endmodule

//--- hdl/mantDivider.sv
/* radix-16 non-restoring mantissa divider
   four chained add/subtract cells per clock, plus a round bit cell */

`include "fpDiv_defs.svh"

module mantDivider
(
  input  logic               Clk_CI,
  input  logic               Rst_RBI,
  input  logic               Load,
  input  logic               Iterate,
  divOperandIf.mant          Ops,
  output fpFormatPkg::mant_t Quotient,
  output logic               RoundBit
);

  import fpFormatPkg::*;

  rem_t  numExt;
  rem_t  denExt;
  rem_t  remReg;
  mant_t quotReg;
  mant_t quotNext;
  rem_t  cellRem [`CELLS_PER_CYCLE];
  rem_t  roundRem;
  logic [`CELLS_PER_CYCLE-1:0] qBits;   // cell 0 in the MSB

  // one non-restoring step, sign of the result is the inverted quotient bit
  function automatic rem_t cellStep(rem_t partRem, logic subtract, rem_t divisor);
    return subtract ? rem_t'(partRem - divisor) : rem_t'(partRem + divisor);
  endfunction

  assign numExt = rem_t'({1'b0, Ops.Numerator});
  assign denExt = rem_t'({1'b0, Ops.Denominator});

  ////////////////////////////////////////////////////////////
  // cell chain
  ////////////////////////////////////////////////////////////

  always_comb
  begin : cellChain
    rem_t cellIn;
    logic subtract;
    cellIn   = Load ? numExt : {remReg[`MANT_WIDTH-1:0], 1'b0};
    subtract = Load | quotReg[0];   // first step always subtracts
    for (int i = 0; i < `CELLS_PER_CYCLE; i++)
    begin
      cellRem[i] = cellStep(cellIn, subtract, denExt);
      qBits[`CELLS_PER_CYCLE-1-i] = ~cellRem[i][`MANT_WIDTH];
      // remainder doubles between cells
      cellIn   = {cellRem[i][`MANT_WIDTH-1:0], 1'b0};
      subtract = qBits[`CELLS_PER_CYCLE-1-i];
    end
    // one step past the 24 quotient bits
    roundRem = cellStep(cellIn, subtract, denExt);
  end

  assign quotNext = {quotReg[`MANT_WIDTH-`CELLS_PER_CYCLE-1:0], qBits};

  // look-ahead view, the assembler latches in the cycle of the last step
  assign Quotient = quotNext;
  assign RoundBit = ~roundRem[`MANT_WIDTH];

  ////////////////////////////////////////////////////////////
  // remainder and quotient registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      remReg  <= '0;
      quotReg <= '0;
    end
    else if (Iterate)
    begin
      remReg  <= cellRem[`CELLS_PER_CYCLE-1];
      quotReg <= quotNext;   // 4 bits per clock
    end
  end

  // normalized divisor keeps the remainder inside 25 bits
  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
                   Load |-> Ops.Denominator[`MANT_WIDTH-1])
    else $error("mantDivider: denominator without hidden bit");

endmodule

//--- hdl/resultAssembler.sv
/* result assembler
   rounds the quotient and holds mantissa and exponent until the next result */

module resultAssembler
(
  input  logic                 Clk_CI,
  input  logic                 Rst_RBI,
  input  logic                 Last,
  input  fpFormatPkg::mant_t   Quotient,
  input  logic                 RoundBit,
  input  fpFormatPkg::expRes_t ExpDiff,
  output fpFormatPkg::mant_t   MantResult,
  output fpFormatPkg::expRes_t ExpResult
);

  import fpFormatPkg::*;

  mant_t mantRounded;

  // round half up, an all-ones quotient wraps to zero
  assign mantRounded = mant_t'(Quotient + mant_t'(RoundBit));

  ////////////////////////////////////////////////////////////
  // result registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      MantResult <= '0;
      ExpResult  <= '0;
    end
    else if (Last)
    begin
      MantResult <= mantRounded;
      ExpResult  <= ExpDiff;   // prenormalized, no adjust for quotient < 1
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# build and run the divider testbench with Verilator, output goes to sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f src.f --top-module tb_fpDivCore -o tb_fpDivCore \
  && ./obj_dir/tb_fpDivCore > sim.log 2>&1 \
  || { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "^Testbench passed$" sim.log \
  && echo "result: PASS" \
  || { echo "result: FAIL"; exit 1; }

//--- src.f
+incdir+common
common/fpFormatPkg.sv
common/divCtrlPkg.sv
common/divOperandIf.sv
hdl/divSequencer.sv
hdl/mantDivider.sv
hdl/expDivider.sv
hdl/resultAssembler.sv
hdl/fpDivCore.sv
verif/tb_fpDivCore.sv

//--- verif/tb_fpDivCore.sv
/* testbench of the divider core
   directed runs against a reference model of the rounding and exponent rules */

`include "fpDiv_defs.svh"

module tb_fpDivCore;

  import fpFormatPkg::*;

  localparam int DoneTimeout = 20;   // cycles from Start

  logic    Clk_CI;
  logic    Rst_RBI;
  logic    Start;
  mant_t   Numerator;
  mant_t   Denominator;
  exp_t    ExpNum;
  exp_t    ExpDen;
  logic    Ready;
  logic    Done;
  mant_t   MantResult;
  expRes_t ExpResult;

  logic [15:0] lfsrState;
  int          checkCount;
  int          errorCount;

  fpDivCore UUT
  (
    .Clk_CI      (Clk_CI),
    .Rst_RBI     (Rst_RBI),
    .Start       (Start),
    .Numerator   (Numerator),
    .Denominator (Denominator),
    .ExpNum      (ExpNum),
    .ExpDen      (ExpDen),
    .Ready       (Ready),
    .Done        (Done),
    .MantResult  (MantResult),
    .ExpResult   (ExpResult)
  );

  always #10 Clk_CI = ~Clk_CI;

  ////////////////////////////////////////////////////////////
  // random source and reference model
  ////////////////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsrNext(logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  function automatic logic [31:0] takeBits(int count);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < count; i++)
    begin
      lfsrState = lfsrNext(lfsrState);
      bits      = {bits[30:0], lfsrState[0]};   // one step per bit
    end
    return bits;
  endfunction

  // round half up of num * 2^23 / den
  function automatic mant_t expectedMant(mant_t num, mant_t den);
    logic [63:0] scaled;
    scaled = ({40'd0, num} << 24) / {40'd0, den};
    scaled = scaled + 64'd1;
    return mant_t'(scaled >> 1);
  endfunction

  function automatic expRes_t expectedExp(exp_t en, exp_t ed);
    int diff;
    diff = int'(en) - int'(ed) + `EXP_BIAS;
    return expRes_t'(diff);   // mod 512
  endfunction

  ////////////////////////////////////////////////////////////
  // checking helpers
  ////////////////////////////////////////////////////////////

  task automatic checkValue(string name, logic [31:0] got, logic [31:0] want);
    checkCount++;
    assert (got === want)
    else
    begin
      errorCount++;
      $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, want);
    end
  endtask

  task automatic reportTest(string name, int errorsBefore);
    int errs;
    errs = errorCount - errorsBefore;
    $display("test %-16s %s (%0d errors)", name, (errs == 0) ? "ok" : "with errors", errs);
  endtask

  task automatic abortRun(string why);
    $display("ERROR at t=%0t: %s", $time, why);
    $display("checks: %0d, errors: %0d", checkCount, errorCount + 1);
    $display("Testbench failed");
    $finish;
  endtask

  // one division with hold and single-pulse checks
  task automatic runDivision(input mant_t num, input mant_t den, input exp_t en,
                             input exp_t ed, output int latency);
    mant_t   heldMant;
    expRes_t heldExp;
    heldMant = MantResult;
    heldExp  = ExpResult;
    @(posedge Clk_CI);
    Numerator   <= num;
    Denominator <= den;
    ExpNum      <= en;
    ExpDen      <= ed;
    Start       <= 1'b1;
    @(posedge Clk_CI);   // start taken here
    Start   <= 1'b0;
    latency = 0;
    do
    begin
      @(negedge Clk_CI);
      latency++;
      if (!Done)
      begin
        checkValue("Ready", 32'(Ready), 32'd0);
        checkValue("MantResult", 32'(MantResult), 32'(heldMant));
        checkValue("ExpResult", 32'(ExpResult), 32'(heldExp));
      end
    end
    while (!Done && latency < DoneTimeout);
    if (!Done)
    begin
      abortRun("Done did not arrive within the timeout");
    end
    else
    begin
      checkValue("Ready", 32'(Ready), 32'd1);
      checkValue("MantResult", 32'(MantResult), 32'(expectedMant(num, den)));
      checkValue("ExpResult", 32'(ExpResult), 32'(expectedExp(en, ed)));
      @(negedge Clk_CI);
      checkValue("Done", 32'(Done), 32'd0);   // single pulse
    end
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic checkResetState();
    int errorsBefore;
    errorsBefore = errorCount;
    @(negedge Clk_CI);
    checkValue("Ready", 32'(Ready), 32'd1);
    checkValue("Done", 32'(Done), 32'd0);
    checkValue("MantResult", 32'(MantResult), 32'd0);
    checkValue("ExpResult", 32'(ExpResult), 32'd0);
    reportTest("resetState", errorsBefore);
  endtask

  task automatic equalMantissaRun();
    int errorsBefore;
    int latency;
    errorsBefore = errorCount;
    runDivision(24'hC00000, 24'hC00000, 8'd140, 8'd100, latency);
    checkValue("latency", 32'(latency), 32'd7);
    checkValue("MantResult", 32'(MantResult), 32'h800000);   // prior Done cycle
    reportTest("equalMantissas", errorsBefore);
  endtask

  task automatic chosenPairRuns();
    int errorsBefore;
    int latency;
    errorsBefore = errorCount;
    runDivision(24'hC00000, 24'h800000, 8'd127, 8'd127, latency);  // 1.5 / 1.0
    runDivision(24'h800000, 24'hC00000, 8'd130, 8'd120, latency);  // below 1.0
    runDivision(24'hFFFFFF, 24'h800000, 8'd200, 8'd60, latency);   // max over min
    runDivision(24'h800000, 24'hFFFFFF, 8'd60, 8'd200, latency);
    // 1.25 / 1.5 rounds up and the exponent wraps
    runDivision(24'hA00000, 24'hC00000, 8'd3, 8'd250, latency);
    reportTest("chosenPairs", errorsBefore);
  endtask

  task automatic randomOperandRuns();
    int          errorsBefore;
    int          latency;
    logic [31:0] bits;
    mant_t       num;
    mant_t       den;
    exp_t        en;
    exp_t        ed;
    errorsBefore = errorCount;
    for (int i = 0; i < 20; i++)
    begin
      bits = takeBits(23);
      num  = {1'b1, bits[22:0]};   // hidden bit always set
      bits = takeBits(23);
      den  = {1'b1, bits[22:0]};
      bits = takeBits(8);
      en   = bits[7:0];
      bits = takeBits(8);
      ed   = bits[7:0];
      if (i % 4 == 0)
      begin
        en = {2'b00, en[5:0]};   // force a negative difference
        ed = {2'b11, ed[5:0]};
      end
      runDivision(num, den, en, ed, latency);
      checkValue("latency", 32'(latency), 32'd7);
    end
    reportTest("randomOperands", errorsBefore);
  endtask

  task automatic resultHoldRun();
    int      errorsBefore;
    int      latency;
    mant_t   heldMant;
    expRes_t heldExp;
    errorsBefore = errorCount;
    runDivision(24'hD55555, 24'h9ABCDE, 8'd90, 8'd33, latency);
    heldMant = MantResult;
    heldExp  = ExpResult;
    for (int i = 0; i < 5; i++)   // idle gap
    begin
      @(negedge Clk_CI);
      checkValue("Done", 32'(Done), 32'd0);
      checkValue("MantResult", 32'(MantResult), 32'(heldMant));
      checkValue("ExpResult", 32'(ExpResult), 32'(heldExp));
    end
    // hold during the next run is checked inside
    runDivision(24'h8F0F0F, 24'hF0F0F1, 8'd10, 8'd11, latency);
    reportTest("resultHold", errorsBefore);
  endtask

  initial
  begin
    Clk_CI      = 1'b0;
    Rst_RBI     = 1'b0;
    Start       = 1'b0;
    Numerator   = 24'h800000;
    Denominator = 24'h800000;
    ExpNum      = '0;
    ExpDen      = '0;
    lfsrState   = 16'd78;
    checkCount  = 0;
    errorCount  = 0;

    repeat (3) @(posedge Clk_CI);
    Rst_RBI <= 1'b1;

    checkResetState();
    equalMantissaRun();
    chosenPairRuns();
    randomOperandRuns();
    resultHoldRun();

    $display("checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule
